//--- hdl/uart_rx_pkg.sv
package uart_rx_pkg;

  // ----------------------------------------------------------
  // Line control word
  // ----------------------------------------------------------
  typedef struct packed {
    logic [1:0] par_sel;   // 0 odd, 1 even, 2 forced 1, 3 forced 0
    logic       par_en;
    logic [1:0] word_len;  // 0..3 is 5..8 bits
  } lcr_fields_t;

  // Same five bits, seen flat or as fields
  typedef union packed {
    logic [4:0]  raw;
    lcr_fields_t fields;
  } lcr_u;

  // Frame FSM states
  typedef enum logic [2:0] {
    RX_IDLE   = 3'd0,
    RX_START  = 3'd1,
    RX_DATA   = 3'd2,
    RX_PAR    = 3'd3,
    RX_STOP   = 3'd4,
    RX_RESYNC = 3'd5
  } rx_state_e;

  // ----------------------------------------------------------
  // Widths and entry layout
  // ----------------------------------------------------------
  localparam int unsigned CHAR_W     = 8;
  localparam int unsigned ENTRY_W    = 11;  // {pe, fe, brk, char}
  localparam int unsigned ENTRY_BRK  = 8;
  localparam int unsigned ENTRY_FE   = 9;
  localparam int unsigned ENTRY_PE   = 10;
  localparam int unsigned FIFO_DEPTH = 16;
  localparam int unsigned USAGE_W    = 5;   // Holds 0..16

  // ----------------------------------------------------------
  // Bit timer and filter
  // ----------------------------------------------------------
  localparam int unsigned OS_W = 5;
  localparam logic [OS_W-1:0] OS_LAST      = 5'd15;
  localparam logic [OS_W-1:0] OS_CENTER    = 5'd8;
  localparam logic [OS_W-1:0] MAJ_INIT     = 5'd4;
  localparam logic [OS_W-1:0] MAJ_DECIDE   = 5'd7;
  localparam logic [OS_W-1:0] START_OFFSET = 5'd2;  // Edge seen on a tick
  localparam int unsigned     SYNC_STAGES  = 2;

  // Trigger thresholds, fifo_tl codes 0..3
  localparam logic [USAGE_W-1:0] TL_1  = 5'd1;
  localparam logic [USAGE_W-1:0] TL_4  = 5'd4;
  localparam logic [USAGE_W-1:0] TL_8  = 5'd8;
  localparam logic [USAGE_W-1:0] TL_14 = 5'd14;

endpackage

//--- hdl/uart_rx_sampler.sv
`timescale 1ns/1ps

module uart_rx_sampler (
  input  logic clk_i,
  input  logic rst_i,
  input  logic rxd_i,          // Raw serial line
  input  logic os_tick_i,      // 16 per bit
  input  logic timer_clear_i,
  input  logic timer_load_i,
  output logic sync_rxd_o,
  output logic rxd_filt_o,
  output logic bit_center_o
);

  import uart_rx_pkg::*;

  logic [SYNC_STAGES-1:0] sync_q;
  logic                   rxd_sync;
  logic [OS_W-1:0]        os_cnt_q;
  logic                   center_now;
  logic                   center_q;
  logic [1:0]             high_cnt_q;  // High samples in this bit
  logic                   filt_q;

  // ----------------------------------------------------------
  // Input synchronizer
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q <= '1;  // Idle line is high
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], rxd_i};
    end
  end

  assign rxd_sync   = sync_q[SYNC_STAGES-1];
  assign sync_rxd_o = rxd_sync;

  // ----------------------------------------------------------
  // Oversample bit timer
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      os_cnt_q <= '0;
    end else if (timer_load_i) begin
      os_cnt_q <= START_OFFSET;  // Start edge landed on a tick
    end else if (timer_clear_i) begin
      os_cnt_q <= '0;
    end else if (os_tick_i) begin
      if (os_cnt_q == OS_LAST) begin
        os_cnt_q <= '0;
      end else begin
        os_cnt_q <= os_cnt_q + 1'b1;
      end
    end
  end

  // Counter sits at centre for a whole tick, pulse only once
  assign center_now = (os_cnt_q == OS_CENTER);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      center_q <= 1'b0;
    end else begin
      center_q <= center_now;
    end
  end

  assign bit_center_o = center_now & ~center_q;

  // Majority of the samples at counts 4, 5 and 6
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      high_cnt_q <= '0;
      filt_q     <= 1'b1;
    end else if (os_tick_i) begin
      if (os_cnt_q == MAJ_INIT) begin
        high_cnt_q <= {1'b0, rxd_sync};  // Restart with first sample
      end else if ((os_cnt_q > MAJ_INIT) && (os_cnt_q < MAJ_DECIDE)) begin
        high_cnt_q <= high_cnt_q + {1'b0, rxd_sync};
      end else if (os_cnt_q == MAJ_DECIDE) begin
        filt_q <= high_cnt_q[1];  // Two or three highs
      end
    end
  end

  assign rxd_filt_o = filt_q;

endmodule

//--- hdl/uart_rx_framer.sv
`timescale 1ns/1ps

module uart_rx_framer (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  uart_rx_pkg::lcr_u             lcr_i,
  input  logic                          sync_rxd_i,
  input  logic                          rxd_filt_i,
  input  logic                          bit_center_i,
  input  logic                          os_tick_i,
  output logic                          timer_clear_o,
  output logic                          timer_load_o,
  output logic                          char_done_o,
  output logic [uart_rx_pkg::ENTRY_W-1:0] char_entry_o
);

  import uart_rx_pkg::*;

  rx_state_e          state_q, state_d;
  logic [CHAR_W-1:0]  shift_q, shift_d;      // Receive shift register
  logic [2:0]         bit_cnt_q, bit_cnt_d;
  logic               ones_q, ones_d;        // Any 1 seen since start bit
  logic               par_err_q, par_err_d;
  logic [2:0]         last_bit;              // Index of final data bit
  logic               data_par;
  logic               stop_center;
  logic               frame_err;
  logic               done_q;
  logic [ENTRY_W-1:0] entry_q, entry_d;

  assign last_bit    = {1'b1, lcr_i.fields.word_len};  // 4..7
  assign data_par    = ^shift_q;  // Unused upper bits stay 0
  assign stop_center = (state_q == RX_STOP) & bit_center_i;
  assign frame_err   = ~rxd_filt_i;

  // ----------------------------------------------------------
  // Frame FSM
  // ----------------------------------------------------------
  always_comb begin
    state_d       = state_q;
    shift_d       = shift_q;
    bit_cnt_d     = bit_cnt_q;
    ones_d        = ones_q;
    par_err_d     = par_err_q;
    timer_clear_o = 1'b0;
    timer_load_o  = 1'b0;

    case (state_q)
      RX_IDLE: begin
        timer_clear_o = 1'b1;  // Timer parked at zero
        if (!sync_rxd_i) begin
          state_d      = RX_START;
          timer_load_o = os_tick_i;
        end
      end

      RX_START: begin
        if (bit_center_i) begin
          if (!rxd_filt_i) begin  // Real start bit
            state_d   = RX_DATA;
            shift_d   = '0;
            bit_cnt_d = '0;
            ones_d    = 1'b0;
            par_err_d = 1'b0;
          end else begin
            state_d = RX_IDLE;  // Glitch, not a start
          end
        end
      end

      RX_DATA: begin
        if (bit_center_i) begin
          shift_d[bit_cnt_q] = rxd_filt_i;  // LSB first
          ones_d             = ones_q | rxd_filt_i;
          bit_cnt_d          = bit_cnt_q + 1'b1;
          if (bit_cnt_q == last_bit) begin
            state_d = lcr_i.fields.par_en ? RX_PAR : RX_STOP;
          end
        end
      end

      RX_PAR: begin
        if (bit_center_i) begin
          case (lcr_i.fields.par_sel)
            2'd0:    par_err_d = (rxd_filt_i == data_par);  // Odd
            2'd1:    par_err_d = (rxd_filt_i != data_par);  // Even
            2'd2:    par_err_d = ~rxd_filt_i;               // Forced 1
            default: par_err_d = rxd_filt_i;                // Forced 0
          endcase
          ones_d  = ones_q | rxd_filt_i;
          state_d = RX_STOP;
        end
      end

      RX_STOP: begin
        if (bit_center_i) begin
          state_d = frame_err ? RX_RESYNC : RX_IDLE;
        end
      end

      RX_RESYNC: begin
        // Line still low, treat as the next start bit
        state_d = sync_rxd_i ? RX_IDLE : RX_START;
      end

      default: state_d = RX_IDLE;
    endcase
  end

  // Entry built at the stop-bit centre
  always_comb begin
    entry_d             = entry_q;
    if (stop_center) begin
      entry_d[CHAR_W-1:0] = shift_q;
      entry_d[ENTRY_BRK]  = ~(ones_q | rxd_filt_i);  // Data, parity, stop all 0
      entry_d[ENTRY_FE]   = frame_err;
      entry_d[ENTRY_PE]   = par_err_q;
    end
  end

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= RX_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= stop_center;  // One cycle after stop centre
    end
  end

  always_ff @(posedge clk_i) begin
    shift_q   <= shift_d;
    bit_cnt_q <= bit_cnt_d;
    ones_q    <= ones_d;
    par_err_q <= par_err_d;
    entry_q   <= entry_d;
  end

  assign char_done_o  = done_q;
  assign char_entry_o = entry_q;

endmodule

//--- hdl/uart_rx_fifo.sv
`timescale 1ns/1ps

module uart_rx_fifo (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            push_i,   // Never while full
  input  logic                            pop_i,    // Never while empty
  input  logic                            flush_i,
  input  logic [uart_rx_pkg::ENTRY_W-1:0] data_i,
  output logic [uart_rx_pkg::ENTRY_W-1:0] data_o,
  output logic                            full_o,
  output logic                            empty_o,
  output logic [uart_rx_pkg::USAGE_W-1:0] usage_o
);

  import uart_rx_pkg::*;

  logic [ENTRY_W-1:0] mem_q [FIFO_DEPTH];
  logic [USAGE_W-2:0] wr_ptr_q;  // Wraps at depth
  logic [USAGE_W-2:0] rd_ptr_q;
  logic [USAGE_W-1:0] usage_q;

  // ----------------------------------------------------------
  // Pointers and fill level
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Both at once leaves the count alone
      if (push_i && !pop_i) begin
        usage_q <= usage_q + 1'b1;
      end else if (pop_i && !push_i) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];  // Head always visible
  assign usage_o = usage_q;
  assign full_o  = (usage_q == USAGE_W'(FIFO_DEPTH));
  assign empty_o = (usage_q == '0);

endmodule

//--- hdl/uart_rx_holding.sv
`timescale 1ns/1ps

module uart_rx_holding (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            char_done_i,
  input  logic [uart_rx_pkg::ENTRY_W-1:0] char_entry_i,
  input  logic [uart_rx_pkg::ENTRY_W-1:0] fifo_head_i,
  input  logic                            fifo_full_i,
  input  logic                            fifo_empty_i,
  input  logic [uart_rx_pkg::USAGE_W-1:0] fifo_usage_i,
  input  logic [1:0]                      fifo_tl_i,
  input  logic                            flush_i,
  input  logic                            rhr_read_i,
  input  logic                            lsr_read_i,
  output logic                            fifo_push_o,
  output logic                            fifo_pop_o,
  output logic                            fifo_flush_o,
  output logic [uart_rx_pkg::ENTRY_W-1:0] fifo_data_o,
  output logic [uart_rx_pkg::CHAR_W-1:0]  rhr_o,
  output logic                            data_ready_o,
  output logic                            par_err_o,
  output logic                            frame_err_o,
  output logic                            break_o,
  output logic                            overrun_o,
  output logic                            trigger_o
);

  import uart_rx_pkg::*;

  logic               held_q;       // Holding register full
  logic [ENTRY_W-1:0] rhr_q;
  logic               overrun_q;
  logic [USAGE_W-1:0] tl_level;

  // ----------------------------------------------------------
  // FIFO strobes
  // ----------------------------------------------------------
  assign fifo_push_o  = char_done_i & ~fifo_full_i;  // Full drops the char
  assign fifo_data_o  = char_entry_i;
  assign fifo_pop_o   = ~held_q & ~fifo_empty_i;
  assign fifo_flush_o = flush_i;                     // Holding register kept

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      held_q <= 1'b0;
    end else if (fifo_pop_o) begin
      held_q <= 1'b1;
    end else if (rhr_read_i) begin
      held_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_pop_o) begin
      rhr_q <= fifo_head_i;  // Load with the pop
    end
  end

  // Sticky until the LSR is read
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      overrun_q <= 1'b0;
    end else if (char_done_i && fifo_full_i) begin
      overrun_q <= 1'b1;
    end else if (lsr_read_i) begin
      overrun_q <= 1'b0;
    end
  end

  // Trigger threshold select
  always_comb begin
    case (fifo_tl_i)
      2'd0:    tl_level = TL_1;
      2'd1:    tl_level = TL_4;
      2'd2:    tl_level = TL_8;
      default: tl_level = TL_14;
    endcase
  end

  assign trigger_o    = (fifo_usage_i >= tl_level);
  assign rhr_o        = rhr_q[CHAR_W-1:0];
  assign data_ready_o = held_q;
  assign par_err_o    = held_q & rhr_q[ENTRY_PE];   // Flags of held entry only
  assign frame_err_o  = held_q & rhr_q[ENTRY_FE];
  assign break_o      = held_q & rhr_q[ENTRY_BRK];
  assign overrun_o    = overrun_q;

endmodule

//--- hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           rxd_i,
  input  logic                           os_tick_i,
  input  uart_rx_pkg::lcr_u              lcr_i,
  input  logic [1:0]                     fifo_tl_i,
  input  logic                           fifo_flush_i,
  input  logic                           rhr_read_i,
  input  logic                           lsr_read_i,
  output logic [uart_rx_pkg::CHAR_W-1:0] rhr_o,
  output logic                           data_ready_o,
  output logic                           par_err_o,
  output logic                           frame_err_o,
  output logic                           break_o,
  output logic                           overrun_o,
  output logic                           trigger_o
);

  import uart_rx_pkg::*;

  // ----------------------------------------------------------
  // Sampler and framer
  // ----------------------------------------------------------
  logic               sync_rxd;
  logic               rxd_filt;
  logic               bit_center;
  logic               timer_clear;
  logic               timer_load;
  logic               char_done;
  logic [ENTRY_W-1:0] char_entry;

  // FIFO side
  logic               fifo_push;
  logic               fifo_pop;
  logic               fifo_flush;
  logic [ENTRY_W-1:0] fifo_wdata;
  logic [ENTRY_W-1:0] fifo_head;
  logic               fifo_full;
  logic               fifo_empty;
  logic [USAGE_W-1:0] fifo_usage;

  uart_rx_sampler i_sampler (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .rxd_i         (rxd_i),
    .os_tick_i     (os_tick_i),
    .timer_clear_i (timer_clear),
    .timer_load_i  (timer_load),
    .sync_rxd_o    (sync_rxd),
    .rxd_filt_o    (rxd_filt),
    .bit_center_o  (bit_center)
  );

  uart_rx_framer i_framer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lcr_i         (lcr_i),
    .sync_rxd_i    (sync_rxd),
    .rxd_filt_i    (rxd_filt),
    .bit_center_i  (bit_center),
    .os_tick_i     (os_tick_i),
    .timer_clear_o (timer_clear),
    .timer_load_o  (timer_load),
    .char_done_o   (char_done),
    .char_entry_o  (char_entry)
  );

  // ----------------------------------------------------------
  // Receive FIFO and holding register
  // ----------------------------------------------------------
  uart_rx_fifo i_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (fifo_push),
    .pop_i   (fifo_pop),
    .flush_i (fifo_flush),
    .data_i  (fifo_wdata),
    .data_o  (fifo_head),
    .full_o  (fifo_full),
    .empty_o (fifo_empty),
    .usage_o (fifo_usage)
  );

  uart_rx_holding i_holding (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .char_done_i  (char_done),
    .char_entry_i (char_entry),
    .fifo_head_i  (fifo_head),
    .fifo_full_i  (fifo_full),
    .fifo_empty_i (fifo_empty),
    .fifo_usage_i (fifo_usage),
    .fifo_tl_i    (fifo_tl_i),
    .flush_i      (fifo_flush_i),
    .rhr_read_i   (rhr_read_i),
    .lsr_read_i   (lsr_read_i),
    .fifo_push_o  (fifo_push),
    .fifo_pop_o   (fifo_pop),
    .fifo_flush_o (fifo_flush),
    .fifo_data_o  (fifo_wdata),
    .rhr_o        (rhr_o),
    .data_ready_o (data_ready_o),
    .par_err_o    (par_err_o),
    .frame_err_o  (frame_err_o),
    .break_o      (break_o),
    .overrun_o    (overrun_o),
    .trigger_o    (trigger_o)
  );

endmodule

//--- bench/uart_rx_tb.sv
`timescale 1ns/1ps

module uart_rx_tb;

  import uart_rx_pkg::*;

  localparam int TICK_CLKS   = 4;
  localparam int BIT_CLKS    = 16 * TICK_CLKS;  // 64 clocks per bit
  localparam int GLITCH_AT   = 18;              // Hits one majority sample
  localparam int FRAME_CLKS  = 12 * BIT_CLKS;   // Longest frame plus idle bit
  localparam int NUM_FRAMES  = 59;              // Frames sent by all tests
  localparam int CYCLE_LIMIT = (NUM_FRAMES + 8) * FRAME_CLKS;  // Slack for gaps, reads

  logic              clk_i;
  logic              rst_i;
  logic              rxd_i;
  logic              os_tick_i;
  lcr_u              lcr_i;
  logic [1:0]        fifo_tl_i;
  logic              fifo_flush_i;
  logic              rhr_read_i;
  logic              lsr_read_i;
  logic [CHAR_W-1:0] rhr_o;
  logic              data_ready_o;
  logic              par_err_o;
  logic              frame_err_o;
  logic              break_o;
  logic              overrun_o;
  logic              trigger_o;

  integer            seed;
  int                cycle_cnt;
  logic [1:0]        tick_phase;

  uart_rx i_dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rxd_i        (rxd_i),
    .os_tick_i    (os_tick_i),
    .lcr_i        (lcr_i),
    .fifo_tl_i    (fifo_tl_i),
    .fifo_flush_i (fifo_flush_i),
    .rhr_read_i   (rhr_read_i),
    .lsr_read_i   (lsr_read_i),
    .rhr_o        (rhr_o),
    .data_ready_o (data_ready_o),
    .par_err_o    (par_err_o),
    .frame_err_o  (frame_err_o),
    .break_o      (break_o),
    .overrun_o    (overrun_o),
    .trigger_o    (trigger_o)
  );

  // ----------------------------------------------------------
  // Clock, oversample tick, run limit
  // ----------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    os_tick_i  = 1'b0;
    tick_phase = '0;
    forever begin
      @(posedge clk_i);
      #1;
      os_tick_i  = (tick_phase == 2'd3);  // One tick every 4 clocks
      tick_phase = tick_phase + 2'd1;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    abort_run($sformatf("Timeout: tests still running after %0d cycles", CYCLE_LIMIT));
  end

  // ----------------------------------------------------------
  // Helpers and compare tasks
  // ----------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;  // Drive and sample just after the edge
  endtask

  task automatic check_char(input logic [CHAR_W-1:0] got, input logic [CHAR_W-1:0] exp,
                            input lcr_u cfg);
    if (got !== exp)
      abort_run($sformatf("Fail at %0d ns: rhr_o is %h, expected %h (lcr %b)",
                          $time, got, exp, cfg.raw));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp)
      abort_run($sformatf("Fail at %0d ns: %s is %b, expected %b", $time, name, got, exp));
  endtask

  function automatic lcr_u make_lcr(input int len, input logic par_en, input logic [1:0] sel);
    lcr_u cfg;
    cfg.fields.word_len = 2'(len - 5);
    cfg.fields.par_en   = par_en;
    cfg.fields.par_sel  = sel;
    return cfg;
  endfunction

  function automatic logic [CHAR_W-1:0] char_mask(input lcr_u cfg);
    return 8'hff >> (2'd3 - cfg.fields.word_len);  // Keep word_len+5 bits
  endfunction

  function automatic logic line_parity(input logic [CHAR_W-1:0] data, input lcr_u cfg);
    logic odd_ones;
    odd_ones = ^(data & char_mask(cfg));
    case (cfg.fields.par_sel)
      2'd0:    return ~odd_ones;  // Odd: total ones odd
      2'd1:    return odd_ones;   // Even
      2'd2:    return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // ----------------------------------------------------------
  // Serial line model
  // ----------------------------------------------------------
  task automatic drive_bit(input logic value, input logic glitch);
    for (int c = 0; c < BIT_CLKS; c++) begin
      if (glitch && c >= GLITCH_AT && c < GLITCH_AT + TICK_CLKS)
        rxd_i = ~value;  // One tick inverted
      else
        rxd_i = value;
      next_cycle();
    end
  endtask

  task automatic send_frame(input logic [CHAR_W-1:0] data, input lcr_u cfg, input logic bad_par,
                            input logic bad_stop, input int glitch_bit);
    int len;
    len = int'(cfg.fields.word_len) + 5;
    drive_bit(1'b0, 1'b0);  // Start
    for (int i = 0; i < len; i++)
      drive_bit(data[i], i == glitch_bit);  // LSB first
    if (cfg.fields.par_en)
      drive_bit(line_parity(data, cfg) ^ bad_par, 1'b0);
    drive_bit(~bad_stop, 1'b0);
    drive_bit(1'b1, 1'b0);  // Idle bit, covers resync after a bad stop
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!data_ready_o) begin
      if (n == 2 * BIT_CLKS)
        abort_run("data_ready_o never rose while waiting for a character");
      next_cycle();
      n++;
    end
  endtask

  task automatic read_char(input logic [CHAR_W-1:0] exp, input logic pe, input logic fe,
                           input logic brk, input lcr_u cfg);
    wait_ready();
    check_char(rhr_o, exp, cfg);
    check_flag(par_err_o, pe, "par_err_o");
    check_flag(frame_err_o, fe, "frame_err_o");
    check_flag(break_o, brk, "break_o");
    rhr_read_i = 1'b1;
    next_cycle();
    rhr_read_i = 1'b0;
  endtask

  // LSR read strobe, one clock
  task automatic read_lsr();
    lsr_read_i = 1'b1;
    next_cycle();
    lsr_read_i = 1'b0;
  endtask

  task automatic flush_fifo();
    fifo_flush_i = 1'b1;
    next_cycle();
    fifo_flush_i = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_8n1();
    lcr_u              cfg;
    logic [CHAR_W-1:0] data;
    cfg = make_lcr(8, 1'b0, 2'd0);
    lcr_i.raw = cfg.raw;
    for (int n = 0; n < 4; n++) begin
      data = CHAR_W'($random(seed));
      send_frame(data, cfg, 1'b0, 1'b0, -1);
      read_char(data, 1'b0, 1'b0, 1'b0, cfg);
      check_flag(data_ready_o, 1'b0, "data_ready_o after read");
    end
  endtask

  task automatic test_parity();
    lcr_u              cfg;
    logic [CHAR_W-1:0] data;
    for (int len = 5; len < 8; len++) begin
      for (int sel = 0; sel < 4; sel++) begin
        cfg = make_lcr(len, 1'b1, 2'(sel));
        lcr_i.raw = cfg.raw;
        data = CHAR_W'($random(seed));
        send_frame(data, cfg, 1'b0, 1'b0, -1);
        read_char(data & char_mask(cfg), 1'b0, 1'b0, 1'b0, cfg);
        data = CHAR_W'($random(seed));
        send_frame(data, cfg, 1'b1, 1'b0, -1);  // Flipped parity bit
        read_char(data & char_mask(cfg), 1'b1, 1'b0, 1'b0, cfg);
      end
    end
  endtask

  task automatic test_stop_break();
    lcr_u              cfg;
    logic [CHAR_W-1:0] data;
    cfg = make_lcr(8, 1'b0, 2'd0);
    lcr_i.raw = cfg.raw;
    data = CHAR_W'($random(seed)) | 8'h01;  // Nonzero, so no break
    send_frame(data, cfg, 1'b0, 1'b1, -1);
    read_char(data, 1'b0, 1'b1, 1'b0, cfg);
    data = CHAR_W'($random(seed));
    send_frame(data, cfg, 1'b0, 1'b0, -1);
    read_char(data, 1'b0, 1'b0, 1'b0, cfg);
    send_frame(8'h00, cfg, 1'b0, 1'b1, -1);  // Line held low
    read_char(8'h00, 1'b0, 1'b1, 1'b1, cfg);
  endtask

  task automatic test_fifo_trigger();
    lcr_u              cfg;
    logic [CHAR_W-1:0] data;
    logic [CHAR_W-1:0] sent [$];
    cfg = make_lcr(8, 1'b0, 2'd0);
    lcr_i.raw = cfg.raw;
    fifo_tl_i = 2'd1;  // Threshold 4
    for (int n = 0; n < 5; n++) begin
      if (n == 4)
        check_flag(trigger_o, 1'b0, "trigger_o before fifth char");
      data = CHAR_W'($random(seed));
      sent.push_back(data);
      send_frame(data, cfg, 1'b0, 1'b0, -1);
    end
    check_flag(trigger_o, 1'b1, "trigger_o after fifth char");  // One held, four queued
    while (sent.size() > 0)
      read_char(sent.pop_front(), 1'b0, 1'b0, 1'b0, cfg);
    fifo_tl_i = 2'd0;
  endtask

  task automatic test_overrun_flush();
    lcr_u              cfg;
    logic [CHAR_W-1:0] data;
    logic [CHAR_W-1:0] sent [$];
    cfg = make_lcr(8, 1'b0, 2'd0);
    lcr_i.raw = cfg.raw;
    for (int n = 0; n < 18; n++) begin
      if (n == 17)
        check_flag(overrun_o, 1'b0, "overrun_o with FIFO just full");
      data = CHAR_W'($random(seed));
      sent.push_back(data);
      send_frame(data, cfg, 1'b0, 1'b0, -1);
    end
    check_flag(overrun_o, 1'b1, "overrun_o after 18th char");
    read_lsr();
    check_flag(overrun_o, 1'b0, "overrun_o after LSR read");
    for (int n = 0; n < 17; n++)
      read_char(sent.pop_front(), 1'b0, 1'b0, 1'b0, cfg);
    check_flag(data_ready_o, 1'b0, "data_ready_o, 18th char kept");
    sent.delete();
    // Three more, then flush behind the held one
    for (int n = 0; n < 3; n++) begin
      data = CHAR_W'($random(seed));
      sent.push_back(data);
      send_frame(data, cfg, 1'b0, 1'b0, -1);
    end
    flush_fifo();
    read_char(sent[0], 1'b0, 1'b0, 1'b0, cfg);
    for (int c = 0; c < BIT_CLKS; c++) begin
      check_flag(data_ready_o, 1'b0, "data_ready_o after flush");
      next_cycle();
    end
  endtask

  task automatic test_glitch();
    lcr_u              cfg;
    logic [CHAR_W-1:0] data;
    cfg = make_lcr(8, 1'b0, 2'd0);
    lcr_i.raw = cfg.raw;
    rxd_i = 1'b0;  // Short low pulse on idle line
    repeat (TICK_CLKS) next_cycle();
    rxd_i = 1'b1;
    // A false start would finish its frame inside this window
    for (int c = 0; c < FRAME_CLKS; c++) begin
      check_flag(data_ready_o, 1'b0, "data_ready_o after idle glitch");
      next_cycle();
    end
    data = CHAR_W'($random(seed));
    send_frame(data, cfg, 1'b0, 1'b0, 0);
    read_char(data, 1'b0, 1'b0, 1'b0, cfg);
    data = CHAR_W'($random(seed));
    send_frame(data, cfg, 1'b0, 1'b0, 5);
    read_char(data, 1'b0, 1'b0, 1'b0, cfg);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    seed         = 32'hbee9;
    rst_i        = 1'b1;
    rxd_i        = 1'b1;  // Idle line
    lcr_i.raw    = '0;
    fifo_tl_i    = 2'd0;
    fifo_flush_i = 1'b0;
    rhr_read_i   = 1'b0;
    lsr_read_i   = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    next_cycle();
    check_flag(data_ready_o, 1'b0, "data_ready_o after reset");
    check_flag(overrun_o, 1'b0, "overrun_o after reset");
    check_flag(trigger_o, 1'b0, "trigger_o after reset");
    test_8n1();
    test_parity();
    test_stop_break();
    test_fifo_trigger();
    test_overrun_flush();
    test_glitch();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- flist.f
hdl/uart_rx_pkg.sv
hdl/uart_rx_sampler.sv
hdl/uart_rx_framer.sv
hdl/uart_rx_fifo.sv
hdl/uart_rx_holding.sv
hdl/uart_rx.sv
bench/uart_rx_tb.sv

//--- Makefile
# Verilator build and run for the UART receiver testbench

VERILATOR ?= verilator
TOP       ?= uart_rx_tb
FLAGS     ?= --binary --timing --timescale 1ns/1ps

SRCS := $(shell cat flist.f)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): flist.f $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f flist.f

# Pass only when the testbench printed its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
